// ==== src/alu_isa_pkg.sv ====
`default_nettype none

package alu_isa_pkg;

    // ========================================
    // Operand and register types
    // ========================================

    // Operands and results of every operation are one 32 bit word
    typedef logic [31:0] data_word_t;

    // Destination register number for the writeback port
    typedef logic [4:0] reg_idx_t;

    // ========================================
    // Operation set
    // ========================================

    // Shifts take their amount from the low 5 bits of operand B
    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_AND = 3'd2,
        OP_OR  = 3'd3,
        OP_XOR = 3'd4,
        OP_SLL = 3'd5,
        OP_SRL = 3'd6,
        OP_MUL = 3'd7
    } alu_op_e;

    // The multiplier retires 2 bits of operand B per iteration
    localparam int MUL_STEPS = 16;

endpackage : alu_isa_pkg

`default_nettype wire

// ==== src/backend_types_pkg.sv ====
`default_nettype none

package backend_types_pkg;

    import alu_isa_pkg::*;

    // Tag width allows a reorder buffer of up to 16 entries
    typedef logic [3:0] rob_tag_t;

    // ========================================
    // Wishbone write payload
    // ========================================

    typedef struct packed {
        alu_op_e    op;
        reg_idx_t   dest;
        data_word_t src_a;
        data_word_t src_b;
    } issue_op_t;

    // ========================================
    // Traffic between blocks
    // ========================================

    // Request from the dispatcher, valid for a single cycle
    typedef struct packed {
        logic      valid;
        rob_tag_t  tag;
        issue_op_t op;
    } lane_req_t;

    // Result from a lane, valid for a single cycle
    typedef struct packed {
        logic       valid;
        rob_tag_t   tag;
        reg_idx_t   dest;
        data_word_t result;
    } lane_result_t;

    // One slot of the reorder buffer
    typedef struct packed {
        logic       done;
        reg_idx_t   dest;
        data_word_t result;
    } rob_entry_t;

endpackage : backend_types_pkg

`default_nettype wire

// ==== src/issue_dispatcher.sv ====
`timescale 1ns/1ps
`default_nettype none

module issue_dispatcher
    import backend_types_pkg::*;
#(
    parameter int NUM_LANES = 3,
    parameter int ROB_DEPTH = 8
) (
    input  wire logic                       clk_i,
    input  wire logic                       rst_n_i,

    // Wishbone classic slave
    input  wire logic                       wb_cyc_i,
    input  wire logic                       wb_stb_i,
    input  wire issue_op_t                  wb_dat_i,
    output logic                            wb_ack_o,

    // Lane side
    input  wire logic [NUM_LANES-1:0]       lane_idle_i,
    output lane_req_t [NUM_LANES-1:0]       lane_req_o,

    // Reorder buffer side
    input  wire logic                       rob_full_i,
    output logic                            alloc_o
);

    localparam int IDX_W = $clog2(ROB_DEPTH);

    logic                 accept;
    logic [NUM_LANES-1:0] grant;
    logic                 ack_q;
    logic [NUM_LANES-1:0] req_valid_q;
    logic [IDX_W-1:0]     alloc_ptr_q;
    rob_tag_t             tag_q;
    issue_op_t            op_q;

    // Isolate the lowest set bit so the lowest numbered idle lane wins
    assign grant = lane_idle_i & ~(lane_idle_i - NUM_LANES'(1));

    // A transfer is taken only when a lane and a buffer slot are free
    // Blocking on ack_q keeps ack to one cycle per transfer
    assign accept = wb_cyc_i & wb_stb_i & (|lane_idle_i) & ~rob_full_i & ~ack_q;

    // ========================================
    // Handshake and allocation state
    // ========================================

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            ack_q       <= 1'b0;
            req_valid_q <= '0;
            alloc_ptr_q <= '0;
        end else begin
            ack_q       <= accept;
            // Only the granted lane sees a valid request
            req_valid_q <= accept ? grant : '0;
            // The pointer wraps by itself since the depth is a power of two
            if (accept) begin
                alloc_ptr_q <= alloc_ptr_q + 1'b1;
            end
        end
    end

    // The operation and its tag are shared by all lanes
    always_ff @(posedge clk_i) begin
        if (accept) begin
            op_q  <= wb_dat_i;
            tag_q <= rob_tag_t'(alloc_ptr_q);
        end
    end

    always_comb begin
        for (int l = 0; l < NUM_LANES; l++) begin
            lane_req_o[l] = '{valid: req_valid_q[l], tag: tag_q, op: op_q};
        end
    end

    // The buffer counts one entry per acknowledged transfer
    assign wb_ack_o = ack_q;
    assign alloc_o  = ack_q;

endmodule : issue_dispatcher

`default_nettype wire

// ==== src/exec_lane.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_lane
    import alu_isa_pkg::*, backend_types_pkg::*;
(
    input  wire logic         clk_i,
    input  wire logic         rst_n_i,
    input  wire lane_req_t    req_i,
    output logic              idle_o,
    output lane_result_t      result_o
);

    localparam int STEP_W = $clog2(MUL_STEPS);

    typedef enum logic [1:0] {
        LANE_IDLE,
        LANE_MUL,
        LANE_DONE
    } lane_state_e;

    lane_state_e       state_q;
    logic [STEP_W-1:0] step_q;
    logic              start;
    logic              last_step;
    data_word_t        alu_result;
    data_word_t        partial;
    data_word_t        acc_q;
    data_word_t        mcand_q;
    data_word_t        mplier_q;
    rob_tag_t          tag_q;
    reg_idx_t          dest_q;

    // The dispatcher only targets an idle lane
    assign start     = (state_q == LANE_IDLE) && req_i.valid;
    assign last_step = (step_q == STEP_W'(MUL_STEPS - 1));

    // ========================================
    // Single cycle datapath
    // ========================================

    always_comb begin
        case (req_i.op.op)
            OP_ADD:  alu_result = req_i.op.src_a + req_i.op.src_b;
            OP_SUB:  alu_result = req_i.op.src_a - req_i.op.src_b;
            OP_AND:  alu_result = req_i.op.src_a & req_i.op.src_b;
            OP_OR:   alu_result = req_i.op.src_a | req_i.op.src_b;
            OP_XOR:  alu_result = req_i.op.src_a ^ req_i.op.src_b;
            OP_SLL:  alu_result = req_i.op.src_a << req_i.op.src_b[4:0];
            OP_SRL:  alu_result = req_i.op.src_a >> req_i.op.src_b[4:0];
            default: alu_result = '0;
        endcase
    end

    // Radix 4 step adds the multiplicand times the two low multiplier bits
    assign partial = (mplier_q[0] ? mcand_q : '0) + (mplier_q[1] ? {mcand_q[30:0], 1'b0} : '0);

    // ========================================
    // Lane control
    // ========================================

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= LANE_IDLE;
            step_q  <= '0;
        end else begin
            case (state_q)
                LANE_IDLE: begin
                    step_q <= '0;
                    if (start) begin
                        state_q <= (req_i.op.op == OP_MUL) ? LANE_MUL : LANE_DONE;
                    end
                end
                LANE_MUL: begin
                    step_q <= step_q + 1'b1;
                    if (last_step) begin
                        state_q <= LANE_DONE;
                    end
                end
                // The result is presented for one cycle
                default: state_q <= LANE_IDLE;
            endcase
        end
    end

    // Tag and destination stay put while the multiplier iterates
    always_ff @(posedge clk_i) begin
        if (start) begin
            tag_q    <= req_i.tag;
            dest_q   <= req_i.op.dest;
            mcand_q  <= req_i.op.src_a;
            mplier_q <= req_i.op.src_b;
            acc_q    <= (req_i.op.op == OP_MUL) ? '0 : alu_result;
        end else if (state_q == LANE_MUL) begin
            // Bits shifted past the top do not touch the low product word
            acc_q    <= acc_q + partial;
            mcand_q  <= mcand_q << 2;
            mplier_q <= mplier_q >> 2;
        end
    end

    assign idle_o   = (state_q == LANE_IDLE);
    assign result_o = '{valid: (state_q == LANE_DONE), tag: tag_q, dest: dest_q, result: acc_q};

endmodule : exec_lane

`default_nettype wire

// ==== src/reorder_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module reorder_buffer
    import alu_isa_pkg::*, backend_types_pkg::*;
#(
    parameter int NUM_LANES = 3,
    parameter int ROB_DEPTH = 8
) (
    input  wire logic                        clk_i,
    input  wire logic                        rst_n_i,

    // Allocation from the dispatcher
    input  wire logic                        alloc_i,
    output logic                             rob_full_o,

    // Results from the lanes, in any order
    input  wire lane_result_t [NUM_LANES-1:0] lane_result_i,

    // In order register writeback
    output logic                             wb_valid_o,
    output reg_idx_t                         wb_reg_o,
    output data_word_t                       wb_data_o
);

    localparam int IDX_W = $clog2(ROB_DEPTH);

    rob_entry_t       entries [ROB_DEPTH];
    logic [IDX_W-1:0] head_q;
    logic [IDX_W:0]   count_q;
    logic             retire;
    logic             wb_valid_q;
    reg_idx_t         wb_reg_q;
    data_word_t       wb_data_q;

    // The head leaves as soon as its result has arrived
    assign retire = entries[head_q].done;

    // ========================================
    // Entry store
    // ========================================

    // Tags are unique so no two lanes ever write the same slot
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < ROB_DEPTH; i++) begin
                entries[i].done <= 1'b0;
            end
        end else begin
            // A retired slot is free again until its tag comes back around
            if (retire) begin
                entries[head_q].done <= 1'b0;
            end
            for (int l = 0; l < NUM_LANES; l++) begin
                if (lane_result_i[l].valid) begin
                    entries[lane_result_i[l].tag[IDX_W-1:0]] <= '{
                        done:   1'b1,
                        dest:   lane_result_i[l].dest,
                        result: lane_result_i[l].result
                    };
                end
            end
        end
    end

    // ========================================
    // Head pointer and occupancy
    // ========================================

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            head_q     <= '0;
            count_q    <= '0;
            wb_valid_q <= 1'b0;
        end else begin
            wb_valid_q <= retire;
            if (retire) begin
                head_q <= head_q + 1'b1;
            end
            // An allocation and a retirement in one cycle cancel out
            case ({alloc_i, retire})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (retire) begin
            wb_reg_q  <= entries[head_q].dest;
            wb_data_q <= entries[head_q].result;
        end
    end

    // Full stops the dispatcher from reusing a tag still in flight
    assign rob_full_o = (count_q == (IDX_W + 1)'(ROB_DEPTH));

    assign wb_valid_o = wb_valid_q;
    assign wb_reg_o   = wb_reg_q;
    assign wb_data_o  = wb_data_q;

endmodule : reorder_buffer

`default_nettype wire

// ==== src/exec_backend.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_backend
    import alu_isa_pkg::*, backend_types_pkg::*;
#(
    parameter int NUM_LANES = 3,
    parameter int ROB_DEPTH = 8
) (
    input  wire logic       clk_i,
    input  wire logic       rst_n_i,

    // Wishbone classic slave
    input  wire logic       wb_cyc_i,
    input  wire logic       wb_stb_i,
    input  wire issue_op_t  wb_dat_i,
    output logic            wb_ack_o,

    // Register writeback, one result per cycle at most
    output logic            wb_valid_o,
    output reg_idx_t        wb_reg_o,
    output data_word_t      wb_data_o
);

    lane_req_t    [NUM_LANES-1:0] lane_req;
    lane_result_t [NUM_LANES-1:0] lane_result;
    logic         [NUM_LANES-1:0] lane_idle;
    logic                         alloc;
    logic                         rob_full;

    // ========================================
    // Issue
    // ========================================

    issue_dispatcher #(
        .NUM_LANES (NUM_LANES),
        .ROB_DEPTH (ROB_DEPTH)
    ) u_dispatch (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .wb_cyc_i    (wb_cyc_i),
        .wb_stb_i    (wb_stb_i),
        .wb_dat_i    (wb_dat_i),
        .wb_ack_o    (wb_ack_o),
        .lane_idle_i (lane_idle),
        .lane_req_o  (lane_req),
        .rob_full_i  (rob_full),
        .alloc_o     (alloc)
    );

    // Lanes run independently and may finish out of order
    for (genvar l = 0; l < NUM_LANES; l++) begin : g_lane
        exec_lane u_lane (
            .clk_i    (clk_i),
            .rst_n_i  (rst_n_i),
            .req_i    (lane_req[l]),
            .idle_o   (lane_idle[l]),
            .result_o (lane_result[l])
        );
    end

    // ========================================
    // In order retirement
    // ========================================

    reorder_buffer #(
        .NUM_LANES (NUM_LANES),
        .ROB_DEPTH (ROB_DEPTH)
    ) u_rob (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .alloc_i       (alloc),
        .rob_full_o    (rob_full),
        .lane_result_i (lane_result),
        .wb_valid_o    (wb_valid_o),
        .wb_reg_o      (wb_reg_o),
        .wb_data_o     (wb_data_o)
    );

endmodule : exec_backend

`default_nettype wire

// ==== bench/exec_backend_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_backend_asserts (
    input wire logic clk_i,
    input wire logic rst_n_i,
    input wire logic wb_cyc_i,
    input wire logic wb_stb_i,
    input wire logic wb_ack_o,
    input wire logic wb_valid_o
);

    // ========================================
    // Wishbone handshake
    // ========================================

    // One ack per transfer, so it never lasts two cycles
    ack_single_cycle: assert property (
        @(posedge clk_i) disable iff (!rst_n_i) wb_ack_o |=> !wb_ack_o
    ) else $error("wb_ack_o stayed high for two consecutive cycles");

    // A rising ack answers a strobe seen in the cycle before
    ack_needs_stb: assert property (
        @(posedge clk_i) disable iff (!rst_n_i) $rose(wb_ack_o) |-> $past(wb_cyc_i && wb_stb_i)
    ) else $error("wb_ack_o rose without cyc and stb in the previous cycle");

    // ========================================
    // Reset values
    // ========================================

    ack_low_after_reset: assert property (
        @(posedge clk_i) !rst_n_i |=> !wb_ack_o
    ) else $error("wb_ack_o high after a reset cycle");

    valid_low_after_reset: assert property (
        @(posedge clk_i) !rst_n_i |=> !wb_valid_o
    ) else $error("wb_valid_o high after a reset cycle");

endmodule : exec_backend_asserts

`default_nettype wire

// ==== bench/exec_backend_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_backend_tb
    import alu_isa_pkg::*, backend_types_pkg::*;
();

    localparam int NUM_LANES    = 3;
    localparam int ROB_DEPTH    = 8;
    localparam int MAX_ENTRIES  = 64;
    localparam int NUM_COLS     = 5;
    localparam int COL_OP       = 0;
    localparam int COL_DEST     = 1;
    localparam int COL_A        = 2;
    localparam int COL_B        = 3;
    localparam int COL_EXP      = 4;
    localparam int RESET_CYCLES = 8;
    localparam int IDLE_CYCLES  = 20;
    localparam int DRAIN_CYCLES = 12;
    localparam logic [31:0] LFSR_SEED = 32'h71e9_9cae;
    // Taps of x^32 + x^22 + x^2 + x + 1 in Galois form
    localparam logic [31:0] LFSR_MASK = 32'h8020_0003;

    logic        clk_i = 1'b0;
    logic        rst_n_i;
    logic        wb_cyc_i;
    logic        wb_stb_i;
    issue_op_t   wb_dat_i;
    logic        wb_ack_o;
    logic        wb_valid_o;
    reg_idx_t    wb_reg_o;
    data_word_t  wb_data_o;

    // Five words per operation, in the column order of the data file
    logic [31:0] vec_mem [MAX_ENTRIES * NUM_COLS];
    int          num_entries = 0;
    logic        load_done   = 1'b0;
    int          ack_count   = 0;
    int          wb_count    = 0;
    int          error_count = 0;
    int          check_count = 0;
    int          max_wait    = 0;
    logic [31:0] lfsr_q;

    exec_backend #(
        .NUM_LANES (NUM_LANES),
        .ROB_DEPTH (ROB_DEPTH)
    ) dut (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .wb_cyc_i   (wb_cyc_i),
        .wb_stb_i   (wb_stb_i),
        .wb_dat_i   (wb_dat_i),
        .wb_ack_o   (wb_ack_o),
        .wb_valid_o (wb_valid_o),
        .wb_reg_o   (wb_reg_o),
        .wb_data_o  (wb_data_o)
    );

    bind exec_backend exec_backend_asserts u_asserts (.*);

    always #2 clk_i = ~clk_i;

    // ========================================
    // Helpers
    // ========================================

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        check_count++;
        if (got !== expected) begin
            error_count++;
            $display("FAIL at %0d ns: %s = %h, expected %h", $time, name, got, expected);
        end
    endtask

    task automatic report_error(input string what);
        error_count++;
        $display("ERROR at %0d ns: %s", $time, what);
    endtask

    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ LFSR_MASK;
        end
        return state >> 1;
    endfunction

    // The LFSR advances once for every bit handed out
    task automatic take_random_bits(input int count, output int value);
        value = 0;
        for (int b = 0; b < count; b++) begin
            value  = (value << 1) | int'(lfsr_q[0]);
            lfsr_q = lfsr_step(lfsr_q);
        end
    endtask

    // Results as the operation set defines them, low 32 bits only
    function automatic data_word_t model_result(input logic [2:0] op, input data_word_t a,
                                                input data_word_t b);
        data_word_t r;
        case (alu_op_e'(op))
            OP_ADD:  r = a + b;
            OP_SUB:  r = a - b;
            OP_AND:  r = a & b;
            OP_OR:   r = a | b;
            OP_XOR:  r = a ^ b;
            OP_SLL:  r = a << b[4:0];
            OP_SRL:  r = a >> b[4:0];
            OP_MUL:  r = a * b;
            default: r = '0;
        endcase
        return r;
    endfunction

    task automatic load_testdata();
        int base;
        // Unused words keep an opcode above 7, which ends the list
        for (int i = 0; i < MAX_ENTRIES * NUM_COLS; i++) begin
            vec_mem[i] = 32'h8000_0000 | 32'(i);
        end
        $readmemh("bench/exec_backend_testdata.txt", vec_mem);
        num_entries = 0;
        while (num_entries < MAX_ENTRIES &&
               vec_mem[num_entries * NUM_COLS + COL_OP] <= 32'd7) begin
            num_entries++;
        end
        if (num_entries == 0) begin
            report_error("no operations found in the test data file");
        end
        // Every expected value in the file must agree with the operation rules
        for (int i = 0; i < num_entries; i++) begin
            base = i * NUM_COLS;
            check_value("testdata expected", vec_mem[base + COL_EXP],
                        model_result(vec_mem[base + COL_OP][2:0], vec_mem[base + COL_A],
                                     vec_mem[base + COL_B]));
        end
    endtask

    // Called 1 ns after a rising edge, returns at the same point of a later cycle
    task automatic issue_transfer(input int idx);
        int waited;
        int base;
        waited = 0;
        base   = idx * NUM_COLS;
        wb_dat_i.op    = alu_op_e'(vec_mem[base + COL_OP][2:0]);
        wb_dat_i.dest  = vec_mem[base + COL_DEST][4:0];
        wb_dat_i.src_a = vec_mem[base + COL_A];
        wb_dat_i.src_b = vec_mem[base + COL_B];
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        @(posedge clk_i);
        #1;
        // Strobe and data stay put for as long as ack is withheld
        while (!wb_ack_o) begin
            waited++;
            @(posedge clk_i);
            #1;
        end
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        if (waited > max_wait) begin
            max_wait = waited;
        end
        // The next operation goes out no earlier than the cycle after ack
        @(posedge clk_i);
        #1;
    endtask

    // ========================================
    // Writeback monitor
    // ========================================

    // Registered outputs are sampled half a cycle after they change
    always @(negedge clk_i) begin
        if (rst_n_i) begin
            if (wb_ack_o) begin
                ack_count++;
            end
            if (wb_valid_o) begin
                if (wb_count >= num_entries) begin
                    report_error("writeback seen with no operation left to retire");
                end else begin
                    check_value("wb_reg_o", 32'(wb_reg_o),
                                vec_mem[wb_count * NUM_COLS + COL_DEST] & 32'h1f);
                    check_value("wb_data_o", wb_data_o,
                                vec_mem[wb_count * NUM_COLS + COL_EXP]);
                end
                wb_count++;
            end
        end
    end

    // ========================================
    // Stimulus
    // ========================================

    initial begin
        int gap;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_dat_i = '0;
        rst_n_i  = 1'b0;
        lfsr_q   = LFSR_SEED;
        load_testdata();
        load_done = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_i);
        #1;
        rst_n_i = 1'b1;
        // With the bus quiet nothing may be acknowledged or retired
        repeat (IDLE_CYCLES) @(posedge clk_i);
        #1;
        check_value("ack count while idle", ack_count, 0);
        check_value("writeback count while idle", wb_count, 0);
        for (int i = 0; i < num_entries; i++) begin
            take_random_bits(2, gap);
            repeat (gap) begin
                @(posedge clk_i);
                #1;
            end
            issue_transfer(i);
        end
        wait (wb_count >= num_entries);
        // Extra cycles would expose a duplicated writeback
        repeat (DRAIN_CYCLES) @(posedge clk_i);
        check_value("ack count", ack_count, num_entries);
        check_value("writeback count", wb_count, num_entries);
        if (max_wait == 0) begin
            report_error("ack was never withheld, so back-pressure was not exercised");
        end
        $display("Closing summary: %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // Budget covers a full multiply plus margin for every operation
    initial begin
        int limit;
        wait (load_done);
        limit = num_entries * (MUL_STEPS + 8) + 100;
        repeat (limit) @(posedge clk_i);
        $display("Timeout: the run did not finish within %0d cycles", limit);
        $display("Errors found");
        $finish;
    end

endmodule : exec_backend_tb

`default_nettype wire

// ==== bench/exec_backend_testdata.txt ====
// Columns: opcode dest operand_a operand_b expected_result, all hex
// Opcodes: 0 add, 1 sub, 2 and, 3 or, 4 xor, 5 sll, 6 srl, 7 mul
0 01 00000005 00000007 0000000c
0 02 ffffffff 00000002 00000001
1 03 00000010 00000003 0000000d
1 04 00000000 00000001 ffffffff
2 05 f0f0f0f0 0ff00ff0 00f000f0
3 06 f0f0f0f0 0ff00ff0 fff0fff0
4 07 f0f0f0f0 0ff00ff0 ff00ff00
5 08 00000001 0000001f 80000000
5 09 00000003 00000021 00000006
6 0a 80000000 0000001f 00000001
6 0b 12345678 00000020 12345678
6 0c ffffffff ffffffe4 0fffffff
7 0d 00000007 00000006 0000002a
7 0e ffffffff ffffffff 00000001
7 0f 00010000 00010000 00000000
7 10 0000abcd 00000100 00abcd00
0 11 00000001 00000001 00000002
4 12 aaaaaaaa 55555555 ffffffff
3 13 00000000 00000000 00000000
1 14 00000064 00000014 00000050
7 15 00000003 00000005 0000000f
7 16 12345678 00000010 23456780
7 17 80000000 00000002 00000000
7 18 0000ffff 0000ffff fffe0001
0 19 7fffffff 00000001 80000000
7 1a 00000100 00000100 00010000
5 1b deadbeef 00000004 eadbeef0
2 1c deadbeef 0000ffff 0000beef
7 1d fffffffe 00000003 fffffffa
6 1e deadbeef 00000010 0000dead
1 1f 00000005 0000000a fffffffb
7 00 00001234 00000002 00002468
4 01 0000ffff 00ff00ff 00ffff00
0 02 11111111 22222222 33333333

// ==== exec_backend.f ====
src/alu_isa_pkg.sv
src/backend_types_pkg.sv
src/issue_dispatcher.sv
src/exec_lane.sv
src/reorder_buffer.sv
src/exec_backend.sv
bench/exec_backend_asserts.sv
bench/exec_backend_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP       = exec_backend_tb
FILELIST  = exec_backend.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = Errors found

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
